/* vlog.f */
design/qa_driver_types_pkg.sv
design/qa_driver_csr_pkg.sv
design/qa_driver_csr.sv
design/qa_driver_mux.sv
design/qa_drv_memory.sv
design/qa_drv_hc_root.sv
design/qa_driver.sv
dv/qa_driver_tb.sv

/* run_sim.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module qa_driver_tb \
    -f vlog.f -o qa_driver_sim

out=$(./obj_dir/qa_driver_sim)
echo "$out"

grep -q "^TEST PASS$" <<< "$out"

/* dv/qa_driver_tb.sv */
// Single-clock testbench; host model answers in order and rings are assumed to hold 8 lines
`timescale 1ns/1ns

module qa_driver_tb
    import qa_driver_types_pkg::*;
    import qa_driver_csr_pkg::*;
;

    // ========================================
    // Run sizing
    // ========================================

    localparam t_csr_addr BASE   = 16'h1b00;
    localparam int  RING         = 8;
    localparam int  N_MEM        = 40;
    localparam int  N_TX         = 20;
    localparam int  N_RX         = 24;
    localparam int  N_SREG       = 3;
    localparam int  TOTAL_OPS    = 2 * N_MEM + N_TX + N_RX + 2 * N_SREG;
    localparam int  CYCLE_LIMIT  = 20 * TOTAL_OPS + 1000;
    localparam t_cl_addr TX_BASE = 32'h0000_0200;
    localparam t_cl_addr RX_BASE = 32'h0000_0400;

    logic clk;
    logic arst_n;
    t_cl_data rx_fifo_data, tx_fifo_data, mem_read_rsp_data, mem_write_data;
    logic rx_fifo_rdy, rx_fifo_enable, tx_fifo_rdy, tx_fifo_enable;
    t_cl_addr mem_read_req_addr, mem_write_addr;
    logic mem_read_req_rdy, mem_read_req_enable, mem_read_rsp_rdy;
    logic mem_write_rdy, mem_write_enable;
    logic [1:0] mem_write_ack;
    t_csr_addr sreg_req_addr, csr_wr_addr;
    logic sreg_req, sreg_ack, csr_wr_valid, sreg_host_valid;
    t_csr_data sreg_rsp, csr_wr_data, sreg_host_data;
    logic sys_req_valid, sys_req_write, sys_req_almfull, sys_rsp_valid, sys_rsp_write;
    t_cl_addr sys_req_addr;
    t_cl_data sys_req_data, sys_rsp_data;
    t_req_tag sys_req_tag, sys_rsp_tag;

    qa_driver #(
        .CSR_HC_BASE_ADDR(BASE),
        .RING_LOG2(3),
        .RX_FIFO_DEPTH_LOG2(2)
    ) uut (.*);

    // Scoreboard state
    int errors = 0;
    int cycle = 0;
    int ack_sum = 0;
    int rd_checked = 0;
    int tx_seen = 0;
    int rx_got = 0;
    int host_valid_cnt = 0;
    int last_due = 0;
    logic almfull_prev = 1'b0;
    t_csr_addr sreg_exp_addr;
    t_cl_data host_mem [t_cl_addr];
    t_cl_data shadow [t_cl_addr];
    t_cl_data rd_exp_q [$];
    t_cl_data tx_exp_q [$];
    // Host response queue with one entry per request
    logic rsp_write_q [$];
    t_req_tag rsp_tag_q [$];
    t_cl_data rsp_data_q [$];
    int rsp_due_q [$];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_eq(input logic [63:0] expected, input logic [63:0] actual,
                            input string what);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    // Reference models of the rx ring contents and the status client
    function automatic t_cl_data rx_line(input int j);
        return {16'hc0de, 16'(j * 7), 32'(j)};
    endfunction

    function automatic t_csr_data status_value(input t_csr_addr a);
        return {a, 16'h05e9, ~a, a ^ 16'h3c3c};
    endfunction

    // ========================================
    // Host memory model
    // ========================================

    always @(posedge clk) begin : host_model
        t_cl_data rd;
        int due;
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors: %0d", errors);
            $display("TEST FAIL");
            $finish;
        end else if (arst_n) begin
            // Grant one clock earlier must have seen almfull low
            check_eq(64'(0), 64'(sys_req_valid && almfull_prev), "request after almfull");
            if (sys_req_valid) begin
                rd = '0;
                if (sys_req_write) begin
                    if (sys_req_tag[TAG_SRC_BIT]) begin
                        check_eq(64'(TX_BASE + t_cl_addr'(tx_seen % RING)),
                                 64'(sys_req_addr), "tx ring slot");
                        if (tx_exp_q.size() == 0)
                            check_eq(64'(0), 64'(1), "tx write with no line sent");
                        else
                            check_eq(tx_exp_q.pop_front(), sys_req_data, "tx line data");
                        tx_seen++;
                    end
                    host_mem[sys_req_addr] = sys_req_data;
                end else if (host_mem.exists(sys_req_addr)) begin
                    rd = host_mem[sys_req_addr];
                end else begin
                    rd = {sys_req_addr, ~sys_req_addr};
                end
                // Random delay but never ahead of an older response
                due = cycle + int'($urandom_range(5, 0));
                if (due < last_due) due = last_due;
                last_due = due;
                rsp_write_q.push_back(sys_req_write);
                rsp_tag_q.push_back(sys_req_tag);
                rsp_data_q.push_back(rd);
                rsp_due_q.push_back(due);
            end
            almfull_prev = sys_req_almfull;
            if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
                sys_rsp_valid <= 1'b1;
                sys_rsp_write <= rsp_write_q.pop_front();
                sys_rsp_tag   <= rsp_tag_q.pop_front();
                sys_rsp_data  <= rsp_data_q.pop_front();
                void'(rsp_due_q.pop_front());
            end else begin
                sys_rsp_valid <= 1'b0;
            end
            sys_req_almfull <= ($urandom_range(9, 0) == 0);
        end
    end

    // ========================================
    // Client side monitors
    // ========================================

    always @(posedge clk) begin
        if (arst_n) begin
            ack_sum += int'(mem_write_ack);
            if (mem_read_rsp_rdy) begin
                if (rd_exp_q.size() == 0)
                    check_eq(64'(0), 64'(1), "read response with no read pending");
                else
                    check_eq(rd_exp_q.pop_front(), mem_read_rsp_data, "memory read data");
                rd_checked++;
            end
            // Pop happens when enable meets a non-empty FIFO
            if (rx_fifo_enable && rx_fifo_rdy) begin
                check_eq(64'(0), 64'(rx_got >= N_RX), "extra rx line");
                check_eq(rx_line(rx_got), rx_fifo_data, "rx line in ring order");
                rx_got++;
            end
            // A line that is not popped on this edge keeps rdy high for the next cycle
            rx_fifo_enable <= rx_fifo_rdy && !rx_fifo_enable &&
                              1'($urandom_range(1, 0));
            if (sreg_host_valid) begin
                host_valid_cnt++;
                check_eq(status_value(sreg_exp_addr), sreg_host_data, "status to host");
            end
        end
    end

    // Four-phase status client
    always @(posedge clk) begin
        if (sreg_req && !sreg_ack) begin
            check_eq(64'(sreg_exp_addr), 64'(sreg_req_addr), "status request address");
            sreg_ack <= 1'b1;
            sreg_rsp <= status_value(sreg_req_addr);
        end else if (!sreg_req && sreg_ack) begin
            sreg_ack <= 1'b0;
        end
    end

    // ========================================
    // Stimulus tasks
    // ========================================

    task automatic csr_write(input t_csr_addr a, input t_csr_data d);
        @(posedge clk);
        csr_wr_valid <= 1'b1;
        csr_wr_addr  <= a;
        csr_wr_data  <= d;
        @(posedge clk);
        csr_wr_valid <= 1'b0;
    endtask

    // Rdy high in a cycle with no enable means the next cycle is rdy too
    task automatic mem_op(input bit is_wr, input t_cl_addr a, input t_cl_data d);
        @(posedge clk);
        while (!(is_wr ? mem_write_rdy : mem_read_req_rdy)) @(posedge clk);
        if (is_wr) begin
            shadow[a] = d;
            mem_write_enable <= 1'b1;
            mem_write_addr   <= a;
            mem_write_data   <= d;
        end else begin
            rd_exp_q.push_back(shadow[a]);
            mem_read_req_enable <= 1'b1;
            mem_read_req_addr   <= a;
        end
        @(posedge clk);
        mem_write_enable    <= 1'b0;
        mem_read_req_enable <= 1'b0;
    endtask

    task automatic run_memory;
        t_cl_addr addrs [N_MEM];
        for (int i = 0; i < N_MEM; i++) begin
            addrs[i] = 32'h1000 + 32'($urandom_range(63, 0));
            mem_op(1'b1, addrs[i], {$urandom, $urandom});
        end
        for (int i = 0; i < N_MEM; i++) mem_op(1'b0, addrs[i], '0);
    endtask

    task automatic run_tx;
        t_cl_data d;
        for (int k = 0; k < N_TX; k++) begin
            d = {$urandom, $urandom};
            @(posedge clk);
            while (!tx_fifo_rdy) @(posedge clk);
            tx_exp_q.push_back(d);
            tx_fifo_enable <= 1'b1;
            tx_fifo_data   <= d;
            @(posedge clk);
            tx_fifo_enable <= 1'b0;
        end
    endtask

    // Fill ring slots only once the old occupant has been delivered
    task automatic run_rx_doorbells;
        int posted;
        int cnt;
        posted = 0;
        while (posted < N_RX) begin
            cnt = int'($urandom_range(4, 1));
            if (cnt > N_RX - posted) cnt = N_RX - posted;
            while (posted + cnt > rx_got + RING) @(posedge clk);
            for (int j = posted; j < posted + cnt; j++)
                host_mem[RX_BASE + t_cl_addr'(j % RING)] = rx_line(j);
            csr_write(BASE + CSR_HC_DOORBELL, t_csr_data'(cnt));
            posted += cnt;
            repeat ($urandom_range(6, 0)) @(posedge clk);
        end
    endtask

    task automatic check_reset_outputs;
        check_eq(64'(0), 64'(sys_req_valid), "sys_req_valid in reset");
        check_eq(64'(0), 64'(sreg_req), "sreg_req in reset");
        check_eq(64'(0), 64'(sreg_host_valid), "sreg_host_valid in reset");
        check_eq(64'(0), 64'(mem_read_rsp_rdy), "mem_read_rsp_rdy in reset");
        check_eq(64'(0), 64'(rx_fifo_rdy), "rx_fifo_rdy in reset");
        check_eq(64'(0), 64'(mem_write_ack), "mem_write_ack in reset");
        check_eq(64'(0), 64'(uut.host_channel.tx_idx), "tx index in reset");
        check_eq(64'(0), 64'(uut.host_channel.rx_idx), "rx index in reset");
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        int exp_cnt;
        t_csr_addr a;
        void'($urandom(32'h7c93));
        arst_n = 1'b0;
        {rx_fifo_enable, tx_fifo_enable, mem_read_req_enable, mem_write_enable} = '0;
        {tx_fifo_data, mem_write_data, mem_read_req_addr, mem_write_addr} = '0;
        {sreg_ack, sreg_rsp, csr_wr_valid, csr_wr_addr, csr_wr_data} = '0;
        {sys_req_almfull, sys_rsp_valid, sys_rsp_write, sys_rsp_tag, sys_rsp_data} = '0;
        sreg_exp_addr = '0;
        repeat (2) @(posedge clk);
        check_reset_outputs();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_reset_outputs();

        csr_write(BASE + CSR_HC_RX_BASE, t_csr_data'(RX_BASE));
        csr_write(BASE + CSR_HC_TX_BASE, t_csr_data'(TX_BASE));

        // Status reads with a second write landing while the exchange is busy
        for (int r = 0; r < N_SREG; r++) begin
            a = 16'($urandom);
            sreg_exp_addr = a;
            exp_cnt = host_valid_cnt + 1;
            csr_write(BASE + CSR_SREG_REQ, t_csr_data'(a));
            csr_write(BASE + CSR_SREG_REQ, t_csr_data'(~a));
            while (host_valid_cnt < exp_cnt) @(posedge clk);
            while (sreg_req || sreg_ack) @(posedge clk);
            repeat (3) @(posedge clk);
            check_eq(64'(exp_cnt), 64'(host_valid_cnt), "status responses to host");
        end

        // Shared port traffic with all clients at once
        fork
            run_memory();
            run_tx();
            run_rx_doorbells();
        join
        while (!(rd_checked == N_MEM && ack_sum == N_MEM && tx_seen == N_TX &&
                 rx_got == N_RX)) @(posedge clk);
        repeat (20) @(posedge clk);
        check_eq(64'(N_MEM), 64'(ack_sum), "write ack total");
        check_eq(64'(N_RX), 64'(rx_got), "rx line total");

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* design/qa_driver.sv */
// Single clock host driver; host responses must come back in request order, one per request
`timescale 1ns/1ns

module qa_driver
    import qa_driver_types_pkg::*;
    import qa_driver_csr_pkg::*;
#(
    parameter t_csr_addr CSR_HC_BASE_ADDR   = 16'h1b00,
    parameter int        RING_LOG2          = 3,
    parameter int        RX_FIFO_DEPTH_LOG2 = 2
) (
    input  logic       clk,
    input  logic       arst_n,

    // Host channel client FIFOs
    output t_cl_data   rx_fifo_data,
    output logic       rx_fifo_rdy,
    input  logic       rx_fifo_enable,
    input  t_cl_data   tx_fifo_data,
    output logic       tx_fifo_rdy,
    input  logic       tx_fifo_enable,

    // Memory client
    input  t_cl_addr   mem_read_req_addr,
    output logic       mem_read_req_rdy,
    input  logic       mem_read_req_enable,
    output t_cl_data   mem_read_rsp_data,
    output logic       mem_read_rsp_rdy,
    input  t_cl_addr   mem_write_addr,
    input  t_cl_data   mem_write_data,
    output logic       mem_write_rdy,
    input  logic       mem_write_enable,
    output logic [1:0] mem_write_ack,

    // Status register client
    output t_csr_addr  sreg_req_addr,
    output logic       sreg_req,
    input  logic       sreg_ack,
    input  t_csr_data  sreg_rsp,

    // Host CSR port
    input  logic       csr_wr_valid,
    input  t_csr_addr  csr_wr_addr,
    input  t_csr_data  csr_wr_data,
    output logic       sreg_host_valid,
    output t_csr_data  sreg_host_data,

    // Host memory port
    output logic       sys_req_valid,
    output logic       sys_req_write,
    output t_cl_addr   sys_req_addr,
    output t_cl_data   sys_req_data,
    output t_req_tag   sys_req_tag,
    input  logic       sys_req_almfull,
    input  logic       sys_rsp_valid,
    input  logic       sys_rsp_write,
    input  t_req_tag   sys_rsp_tag,
    input  t_cl_data   sys_rsp_data
);

    // CSR to channel
    t_cl_addr      hc_rx_base;
    t_cl_addr      hc_tx_base;
    logic          doorbell_valid;
    t_doorbell_cnt doorbell_cnt;

    // Memory client to mux
    logic          mem_req_valid;
    logic          mem_req_write;
    t_cl_addr      mem_req_addr;
    t_cl_data      mem_req_data;
    t_req_tag      mem_req_tag;
    logic          mem_grant;
    logic          mem_rsp_valid;
    logic          mem_rsp_write;
    t_cl_data      mem_rsp_data;

    // Host channel to mux
    logic          chn_req_valid;
    logic          chn_req_write;
    t_cl_addr      chn_req_addr;
    t_cl_data      chn_req_data;
    t_req_tag      chn_req_tag;
    logic          chn_grant;
    logic          chn_rsp_valid;
    logic          chn_rsp_write;
    t_cl_data      chn_rsp_data;

    // ========================================
    // CSR decode and status exchange
    // ========================================

    qa_driver_csr #(
        .CSR_HC_BASE_ADDR(CSR_HC_BASE_ADDR)
    ) csr_mgr (
        .clk, .arst_n,
        .csr_wr_valid, .csr_wr_addr, .csr_wr_data,
        .hc_rx_base, .hc_tx_base, .doorbell_valid, .doorbell_cnt,
        .sreg_req, .sreg_req_addr, .sreg_ack, .sreg_rsp,
        .sreg_host_valid, .sreg_host_data
    );

    // ========================================
    // Host port sharing
    // ========================================

    qa_driver_mux mux (
        .clk, .arst_n,
        .m_req_valid(mem_req_valid), .m_req_write(mem_req_write),
        .m_req_addr(mem_req_addr), .m_req_data(mem_req_data), .m_req_tag(mem_req_tag),
        .m_grant(mem_grant), .m_rsp_valid(mem_rsp_valid),
        .m_rsp_write(mem_rsp_write), .m_rsp_data(mem_rsp_data),
        .c_req_valid(chn_req_valid), .c_req_write(chn_req_write),
        .c_req_addr(chn_req_addr), .c_req_data(chn_req_data), .c_req_tag(chn_req_tag),
        .c_grant(chn_grant), .c_rsp_valid(chn_rsp_valid),
        .c_rsp_write(chn_rsp_write), .c_rsp_data(chn_rsp_data),
        .sys_req_valid, .sys_req_write, .sys_req_addr, .sys_req_data, .sys_req_tag,
        .sys_req_almfull, .sys_rsp_valid, .sys_rsp_write, .sys_rsp_tag, .sys_rsp_data
    );

    // ========================================
    // Clients
    // ========================================

    qa_drv_memory host_memory (
        .clk, .arst_n,
        .mem_read_req_addr, .mem_read_req_rdy, .mem_read_req_enable,
        .mem_read_rsp_data, .mem_read_rsp_rdy,
        .mem_write_addr, .mem_write_data, .mem_write_rdy, .mem_write_enable,
        .mem_write_ack,
        .req_valid(mem_req_valid), .req_write(mem_req_write), .req_addr(mem_req_addr),
        .req_data(mem_req_data), .req_tag(mem_req_tag), .grant(mem_grant),
        .rsp_valid(mem_rsp_valid), .rsp_write(mem_rsp_write), .rsp_data(mem_rsp_data)
    );

    qa_drv_hc_root #(
        .RING_LOG2(RING_LOG2),
        .RX_FIFO_DEPTH_LOG2(RX_FIFO_DEPTH_LOG2)
    ) host_channel (
        .clk, .arst_n,
        .tx_fifo_data, .tx_fifo_rdy, .tx_fifo_enable,
        .rx_fifo_data, .rx_fifo_rdy, .rx_fifo_enable,
        .hc_rx_base, .hc_tx_base, .doorbell_valid, .doorbell_cnt,
        .req_valid(chn_req_valid), .req_write(chn_req_write), .req_addr(chn_req_addr),
        .req_data(chn_req_data), .req_tag(chn_req_tag), .grant(chn_grant),
        .rsp_valid(chn_rsp_valid), .rsp_write(chn_rsp_write), .rsp_data(chn_rsp_data)
    );

endmodule

/* design/qa_drv_hc_root.sv */
// Rings are 2^RING_LOG2 lines; the host must not post more doorbell lines than the ring holds
`timescale 1ns/1ns

module qa_drv_hc_root
    import qa_driver_types_pkg::*;
    import qa_driver_csr_pkg::*;
#(
    parameter int RING_LOG2          = 3,
    parameter int RX_FIFO_DEPTH_LOG2 = 2
) (
    input  logic          clk,
    input  logic          arst_n,

    input  t_cl_data      tx_fifo_data,
    output logic          tx_fifo_rdy,
    input  logic          tx_fifo_enable,
    output t_cl_data      rx_fifo_data,
    output logic          rx_fifo_rdy,
    input  logic          rx_fifo_enable,

    input  t_cl_addr      hc_rx_base,
    input  t_cl_addr      hc_tx_base,
    input  logic          doorbell_valid,
    input  t_doorbell_cnt doorbell_cnt,

    output logic          req_valid,
    output logic          req_write,
    output t_cl_addr      req_addr,
    output t_cl_data      req_data,
    output t_req_tag      req_tag,
    input  logic          grant,
    input  logic          rsp_valid,
    input  logic          rsp_write,
    input  t_cl_data      rsp_data
);

    localparam int PEND_W = 16;
    localparam logic [RX_FIFO_DEPTH_LOG2:0] SLOTS_FULL = {1'b1, {RX_FIFO_DEPTH_LOG2{1'b0}}};

    logic                        tx_valid;
    t_cl_data                    tx_data;
    logic [RING_LOG2-1:0]        tx_idx;
    logic [RING_LOG2-1:0]        rx_idx;
    logic [PEND_W-1:0]           pending;
    // FIFO entries plus reads still in flight
    logic [RX_FIFO_DEPTH_LOG2:0] slots_used;
    logic                        rx_want;
    logic                        tx_taken;
    logic                        rx_taken;
    logic                        rx_pop;
    logic                        rx_push;

    // ========================================
    // Request side, tx ahead of rx
    // ========================================

    assign rx_want   = (pending != '0) && (slots_used != SLOTS_FULL);
    assign req_valid = tx_valid || rx_want;
    assign req_write = tx_valid;
    assign req_addr  = tx_valid ? hc_tx_base + t_cl_addr'(tx_idx)
                                : hc_rx_base + t_cl_addr'(rx_idx);
    assign req_data  = tx_data;
    assign req_tag   = t_req_tag'(req_write);

    assign tx_taken    = grant && tx_valid;
    assign rx_taken    = grant && !tx_valid;
    assign tx_fifo_rdy = !tx_valid || tx_taken;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_valid   <= 1'b0;
            tx_idx     <= '0;
            rx_idx     <= '0;
            pending    <= '0;
            slots_used <= '0;
        end else begin
            tx_valid <= (tx_valid && !tx_taken) || tx_fifo_enable;
            // Indexes wrap with the ring
            if (tx_taken) tx_idx <= tx_idx + 1'b1;
            if (rx_taken) rx_idx <= rx_idx + 1'b1;
            pending <= pending + PEND_W'(doorbell_valid ? doorbell_cnt : '0)
                       - PEND_W'(rx_taken);
            slots_used <= slots_used + (RX_FIFO_DEPTH_LOG2+1)'(rx_taken)
                          - (RX_FIFO_DEPTH_LOG2+1)'(rx_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (tx_fifo_enable) tx_data <= tx_fifo_data;
    end

    // ========================================
    // Rx FIFO
    // ========================================

    t_cl_data                    rx_mem [2**RX_FIFO_DEPTH_LOG2];
    // Extra pointer bit tells full from empty
    logic [RX_FIFO_DEPTH_LOG2:0] wr_ptr;
    logic [RX_FIFO_DEPTH_LOG2:0] rd_ptr;

    // Tx write acks are ignored, reads fill the FIFO
    assign rx_push      = rsp_valid && !rsp_write;
    assign rx_pop       = rx_fifo_enable && rx_fifo_rdy;
    assign rx_fifo_rdy  = (wr_ptr != rd_ptr);
    assign rx_fifo_data = rx_mem[rd_ptr[RX_FIFO_DEPTH_LOG2-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (rx_push) wr_ptr <= wr_ptr + 1'b1;
            if (rx_pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_push) rx_mem[wr_ptr[RX_FIFO_DEPTH_LOG2-1:0]] <= rsp_data;
    end

endmodule

/* design/qa_drv_memory.sv */
// One read and one write buffered; a read waits behind a held write so same-line order holds
`timescale 1ns/1ns

module qa_drv_memory
    import qa_driver_types_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    input  t_cl_addr   mem_read_req_addr,
    output logic       mem_read_req_rdy,
    input  logic       mem_read_req_enable,
    output t_cl_data   mem_read_rsp_data,
    output logic       mem_read_rsp_rdy,

    input  t_cl_addr   mem_write_addr,
    input  t_cl_data   mem_write_data,
    output logic       mem_write_rdy,
    input  logic       mem_write_enable,
    output logic [1:0] mem_write_ack,

    output logic       req_valid,
    output logic       req_write,
    output t_cl_addr   req_addr,
    output t_cl_data   req_data,
    output t_req_tag   req_tag,
    input  logic       grant,
    input  logic       rsp_valid,
    input  logic       rsp_write,
    input  t_cl_data   rsp_data
);

    // Request holding registers
    logic     rd_valid;
    t_cl_addr rd_addr;
    logic     wr_valid;
    t_cl_addr wr_addr;
    t_cl_data wr_data;
    logic     rd_taken;
    logic     wr_taken;

    // Read goes first whenever one is held
    assign req_valid = rd_valid || wr_valid;
    assign req_write = !rd_valid;
    assign req_addr  = rd_valid ? rd_addr : wr_addr;
    assign req_data  = wr_data;
    // Low tag bit marks writes for host-side debug
    assign req_tag   = t_req_tag'(req_write);

    assign rd_taken = grant && rd_valid;
    assign wr_taken = grant && !rd_valid;

    // Slot free now or emptied by this cycle's grant
    assign mem_read_req_rdy = !wr_valid && (!rd_valid || rd_taken);
    assign mem_write_rdy    = !wr_valid || wr_taken;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid      <= 1'b0;
            wr_valid      <= 1'b0;
            mem_write_ack <= 2'd0;
        end else begin
            rd_valid      <= (rd_valid && !rd_taken) || mem_read_req_enable;
            wr_valid      <= (wr_valid && !wr_taken) || mem_write_enable;
            // At most one write response per clock
            mem_write_ack <= {1'b0, rsp_valid && rsp_write};
        end
    end

    always_ff @(posedge clk) begin
        if (mem_read_req_enable) rd_addr <= mem_read_req_addr;
        if (mem_write_enable) begin
            wr_addr <= mem_write_addr;
            wr_data <= mem_write_data;
        end
    end

    // Responses return in order, pass reads straight through
    assign mem_read_rsp_rdy  = rsp_valid && !rsp_write;
    assign mem_read_rsp_data = rsp_data;

endmodule

/* design/qa_driver_mux.sv */
// Two-way request merge; client tags must leave bit 7 clear and the host answers in order
`timescale 1ns/1ns

module qa_driver_mux
    import qa_driver_types_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    // Memory client side
    input  logic     m_req_valid,
    input  logic     m_req_write,
    input  t_cl_addr m_req_addr,
    input  t_cl_data m_req_data,
    input  t_req_tag m_req_tag,
    output logic     m_grant,
    output logic     m_rsp_valid,
    output logic     m_rsp_write,
    output t_cl_data m_rsp_data,

    // Host channel side
    input  logic     c_req_valid,
    input  logic     c_req_write,
    input  t_cl_addr c_req_addr,
    input  t_cl_data c_req_data,
    input  t_req_tag c_req_tag,
    output logic     c_grant,
    output logic     c_rsp_valid,
    output logic     c_rsp_write,
    output t_cl_data c_rsp_data,

    // Host port
    output logic     sys_req_valid,
    output logic     sys_req_write,
    output t_cl_addr sys_req_addr,
    output t_cl_data sys_req_data,
    output t_req_tag sys_req_tag,
    input  logic     sys_req_almfull,
    input  logic     sys_rsp_valid,
    input  logic     sys_rsp_write,
    input  t_req_tag sys_rsp_tag,
    input  t_cl_data sys_rsp_data
);

    // ========================================
    // Arbitration
    // ========================================

    // Source served by the most recent grant
    logic     last_src;
    logic     pick_c;
    logic     win_src;
    t_req_tag win_tag;

    // Channel wins when alone or when memory went last
    assign pick_c  = c_req_valid && (!m_req_valid || (last_src == MUX_IDX_MEMORY));
    assign win_src = pick_c ? MUX_IDX_CHANNELS : MUX_IDX_MEMORY;
    assign win_tag = pick_c ? c_req_tag : m_req_tag;

    // Almost full blocks every grant
    assign m_grant = !sys_req_almfull && m_req_valid && !pick_c;
    assign c_grant = !sys_req_almfull && pick_c;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sys_req_valid <= 1'b0;
            last_src      <= MUX_IDX_CHANNELS;
        end else begin
            sys_req_valid <= m_grant || c_grant;
            if (m_grant || c_grant) last_src <= win_src;
        end
    end

    // Winning request lands on the host port one clock after grant
    always_ff @(posedge clk) begin
        if (m_grant || c_grant) begin
            sys_req_write <= pick_c ? c_req_write : m_req_write;
            sys_req_addr  <= pick_c ? c_req_addr : m_req_addr;
            sys_req_data  <= pick_c ? c_req_data : m_req_data;
            sys_req_tag   <= {win_src, win_tag[TAG_SRC_BIT-1:0]};
        end
    end

    // ========================================
    // Response routing by tag source bit
    // ========================================

    assign m_rsp_valid = sys_rsp_valid && (sys_rsp_tag[TAG_SRC_BIT] == MUX_IDX_MEMORY);
    assign c_rsp_valid = sys_rsp_valid && (sys_rsp_tag[TAG_SRC_BIT] == MUX_IDX_CHANNELS);
    assign m_rsp_write = sys_rsp_write;
    assign c_rsp_write = sys_rsp_write;
    assign m_rsp_data  = sys_rsp_data;
    assign c_rsp_data  = sys_rsp_data;

endmodule

/* design/qa_driver_csr.sv */
// CSR writes are single cycle and never stalled; a status request is dropped while busy
`timescale 1ns/1ns

module qa_driver_csr
    import qa_driver_types_pkg::*;
    import qa_driver_csr_pkg::*;
#(
    parameter t_csr_addr CSR_HC_BASE_ADDR = 16'h1b00
) (
    input  logic          clk,
    input  logic          arst_n,

    input  logic          csr_wr_valid,
    input  t_csr_addr     csr_wr_addr,
    input  t_csr_data     csr_wr_data,

    output t_cl_addr      hc_rx_base,
    output t_cl_addr      hc_tx_base,
    output logic          doorbell_valid,
    output t_doorbell_cnt doorbell_cnt,

    output logic          sreg_req,
    output t_csr_addr     sreg_req_addr,
    input  logic          sreg_ack,
    input  t_csr_data     sreg_rsp,
    output logic          sreg_host_valid,
    output t_csr_data     sreg_host_data
);

    // ========================================
    // Address decode
    // ========================================

    localparam t_csr_addr ADDR_RX_BASE  = CSR_HC_BASE_ADDR + CSR_HC_RX_BASE;
    localparam t_csr_addr ADDR_TX_BASE  = CSR_HC_BASE_ADDR + CSR_HC_TX_BASE;
    localparam t_csr_addr ADDR_DOORBELL = CSR_HC_BASE_ADDR + CSR_HC_DOORBELL;
    localparam t_csr_addr ADDR_SREG_REQ = CSR_HC_BASE_ADDR + CSR_SREG_REQ;

    logic        wr_rx_base;
    logic        wr_tx_base;
    logic        wr_doorbell;
    logic        wr_sreg;
    t_sreg_state sreg_state;

    assign wr_rx_base  = csr_wr_valid && (csr_wr_addr == ADDR_RX_BASE);
    assign wr_tx_base  = csr_wr_valid && (csr_wr_addr == ADDR_TX_BASE);
    assign wr_doorbell = csr_wr_valid && (csr_wr_addr == ADDR_DOORBELL);
    // Only an idle engine takes a new status request
    assign wr_sreg     = csr_wr_valid && (csr_wr_addr == ADDR_SREG_REQ) &&
                         (sreg_state == SREG_IDLE);

    // Ring bases and doorbell pulse, visible one clock after the write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hc_rx_base     <= '0;
            hc_tx_base     <= '0;
            doorbell_valid <= 1'b0;
        end else begin
            if (wr_rx_base) hc_rx_base <= csr_wr_data[CL_ADDR_WIDTH-1:0];
            if (wr_tx_base) hc_tx_base <= csr_wr_data[CL_ADDR_WIDTH-1:0];
            doorbell_valid <= wr_doorbell;
        end
    end

    // ========================================
    // Status register four-phase engine
    // ========================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sreg_state <= SREG_IDLE;
        end else begin
            case (sreg_state)
                SREG_IDLE:      if (wr_sreg) sreg_state <= SREG_REQ;
                // Client answered, hand the value to the host
                SREG_REQ:       if (sreg_ack) sreg_state <= SREG_RSP;
                // Ack may already be gone by now
                SREG_RSP:       sreg_state <= sreg_ack ? SREG_WAIT_DROP : SREG_IDLE;
                SREG_WAIT_DROP: if (!sreg_ack) sreg_state <= SREG_IDLE;
                default:        sreg_state <= SREG_IDLE;
            endcase
        end
    end

    // Payload captures
    always_ff @(posedge clk) begin
        if (wr_doorbell) doorbell_cnt <= csr_wr_data[$bits(t_doorbell_cnt)-1:0];
        if (wr_sreg) sreg_req_addr <= csr_wr_data[$bits(t_csr_addr)-1:0];
        if (sreg_state == SREG_REQ && sreg_ack) sreg_host_data <= sreg_rsp;
    end

    assign sreg_req        = (sreg_state == SREG_REQ);
    assign sreg_host_valid = (sreg_state == SREG_RSP);

endmodule

/* design/qa_driver_csr_pkg.sv */
// CSR map as word offsets from the block base; only one status read may be in flight
package qa_driver_csr_pkg;

    typedef logic [15:0] t_csr_addr;
    typedef logic [63:0] t_csr_data;

    // Lines posted by the host in one doorbell write
    typedef logic [7:0]  t_doorbell_cnt;

    // Offsets from CSR_HC_BASE_ADDR
    localparam t_csr_addr CSR_HC_RX_BASE  = 16'h0000;
    localparam t_csr_addr CSR_HC_TX_BASE  = 16'h0001;
    localparam t_csr_addr CSR_HC_DOORBELL = 16'h0002;
    localparam t_csr_addr CSR_SREG_REQ    = 16'h0003;

    // Status register exchange with the FPGA client
    typedef enum logic [1:0] {
        SREG_IDLE,
        SREG_REQ,
        SREG_WAIT_DROP,
        SREG_RSP
    } t_sreg_state;

endpackage

/* design/qa_driver_types_pkg.sv */
// Data path types; lines are 64 bits for simulation and tag bit 7 is reserved for the mux
package qa_driver_types_pkg;

    // ========================================
    // Widths
    // ========================================

    // Narrow line, a real host line is 512 bits
    localparam int CL_DATA_WIDTH = 64;
    // Fixed line address width, clients must match it
    localparam int CL_ADDR_WIDTH = 32;
    localparam int REQ_TAG_WIDTH = 8;

    // Tag bit that records the request source inside the mux
    localparam int TAG_SRC_BIT = 7;

    typedef logic [CL_DATA_WIDTH-1:0] t_cl_data;
    typedef logic [CL_ADDR_WIDTH-1:0] t_cl_addr;
    typedef logic [REQ_TAG_WIDTH-1:0] t_req_tag;

    // ========================================
    // Mux source encoding
    // ========================================

    localparam logic MUX_IDX_MEMORY   = 1'b0;
    localparam logic MUX_IDX_CHANNELS = 1'b1;

endpackage
